//--- Makefile
# Verilator build, run, lint and clean for the TCB memory subordinate

VERILATOR ?= verilator
TOP       ?= tcb_mem_tb
FLIST     ?= tcb_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/tcb_mem_array.sv
// word memory with byte-enable write and asynchronous read-before-write
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_array #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire logic               tcb,
  // word index and write strobe from control
  input  wire tcb_pkg::tcb_widx_t widx,
  input  wire logic               wr_en,
  // write payload
  input  wire tcb_pkg::tcb_ben_t  ben,
  input  wire tcb_pkg::tcb_dat_t  wdt,
  // read data of the addressed word
  output tcb_pkg::tcb_dat_t       rdt
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // index width needed for the array itself
  localparam int unsigned MIW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  tcb_pkg::tcb_dat_t mem [0:MEM_WORDS-1];

  // low bits of the word index select the entry
  // out of range words never get written, their read data is masked later
  logic [MIW-1:0] midx;

  assign midx = widx[MIW-1:0];

  //////////////////////////////
  // write
  //////////////////////////////

  // only enabled bytes change
  always_ff @(posedge tcb) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < tcb_pkg::BEW; b++) begin
        if (ben[b]) begin
          mem[midx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // read
  //////////////////////////////

  // combinational, so a write cycle still sees the old word
  assign rdt = mem[midx];

endmodule : tcb_mem_array

`default_nettype wire

//--- logic/tcb_mem_top.sv
// memory subordinate top, control, memory array and response pipeline
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_top #(
  // response delay, at least 1
  parameter int unsigned DLY       = 2,
  // memory depth in words
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire logic              tcb,
  input  wire logic              rst_n,
  // request
  input  wire logic              vld,
  input  wire tcb_pkg::tcb_req_t req,
  input  wire logic              stall,
  output logic                   rdy,
  // response
  output logic                   rsp_vld,
  output tcb_pkg::tcb_rsp_t      rsp
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  logic               trn;
  logic               wr_en;
  logic               adr_ok;
  tcb_pkg::tcb_widx_t widx;
  tcb_pkg::tcb_dat_t  rdt;

  // handshake and decode
  tcb_sub_ctl #(
    .MEM_WORDS (MEM_WORDS)
  ) tcb_sub_ctl_i (
    .tcb    (tcb),
    .rst_n  (rst_n),
    .vld    (vld),
    .req    (req),
    .stall  (stall),
    .rdy    (rdy),
    .trn    (trn),
    .wr_en  (wr_en),
    .adr_ok (adr_ok),
    .widx   (widx)
  );

  // word storage
  tcb_mem_array #(
    .MEM_WORDS (MEM_WORDS)
  ) tcb_mem_array_i (
    .tcb   (tcb),
    .widx  (widx),
    .wr_en (wr_en),
    .ben   (req.ben),
    .wdt   (req.wdt),
    .rdt   (rdt)
  );

  // fixed latency response
  tcb_rsp_pipe #(
    .DLY (DLY)
  ) tcb_rsp_pipe_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .trn     (trn),
    .adr_ok  (adr_ok),
    .rdt     (rdt),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule : tcb_mem_top

`default_nettype wire

//--- logic/tcb_pkg.sv
// bus widths, vector typedefs, request and response structs
`default_nettype none

package tcb_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // byte address width
  localparam int unsigned ABW = 16;
  // data word width
  localparam int unsigned DBW = 32;
  // byte enables, one per data byte
  localparam int unsigned BEW = DBW / 8;
  // word index width, address without its byte offset
  localparam int unsigned WIW = ABW - 2;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [ABW-1:0] tcb_adr_t;
  typedef logic [DBW-1:0] tcb_dat_t;
  typedef logic [BEW-1:0] tcb_ben_t;
  // word index into the memory
  typedef logic [WIW-1:0] tcb_widx_t;

  //////////////////////////////
  // bus structs
  //////////////////////////////

  // request, valid while vld is high
  typedef struct packed {
    logic     wen;  // write enable
    tcb_adr_t adr;  // byte address
    tcb_ben_t ben;  // byte enables
    tcb_dat_t wdt;  // write data
  } tcb_req_t;

  // response, valid with rsp_vld
  typedef struct packed {
    tcb_dat_t rdt;  // read data
    logic     err;  // address out of range
  } tcb_rsp_t;

endpackage : tcb_pkg

`default_nettype wire

//--- logic/tcb_rsp_pipe.sv
// response delay line of DLY stages, strobe, read data and error
`timescale 1ns/1ps
`default_nettype none

module tcb_rsp_pipe #(
  parameter int unsigned DLY = 2
) (
  input  wire logic              tcb,
  input  wire logic              rst_n,
  // transfer and decode from control
  input  wire logic              trn,
  input  wire logic              adr_ok,
  // old word content from memory
  input  wire tcb_pkg::tcb_dat_t rdt,
  // response towards manager
  output logic                   rsp_vld,
  output tcb_pkg::tcb_rsp_t      rsp
);

  //////////////////////////////
  // stage storage
  //////////////////////////////

  // valid bit per stage
  logic [DLY-1:0]    stg_vld;
  // payload per stage
  tcb_pkg::tcb_rsp_t stg_rsp [0:DLY-1];

  // response formed on the transfer edge
  tcb_pkg::tcb_rsp_t new_rsp;

  // zero data with err for an address out of range
  always_comb begin
    new_rsp.err = ~adr_ok;
    new_rsp.rdt = adr_ok ? rdt : '0;
  end

  //////////////////////////////
  // valid chain
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      stg_vld <= '0;
    end else begin
      stg_vld[0] <= trn;
      for (int unsigned i = 1; i < DLY; i++) begin
        stg_vld[i] <= stg_vld[i-1];
      end
    end
  end

  //////////////////////////////
  // payload chain
  //////////////////////////////

  // a stage loads only when the stage before holds a response
  // so the output keeps its last value between strobes
  always_ff @(posedge tcb) begin
    if (trn) begin
      stg_rsp[0] <= new_rsp;
    end
    for (int unsigned i = 1; i < DLY; i++) begin
      if (stg_vld[i-1]) begin
        stg_rsp[i] <= stg_rsp[i-1];
      end
    end
  end

  // last stage drives the bus
  assign rsp_vld = stg_vld[DLY-1];
  assign rsp     = stg_rsp[DLY-1];

endmodule : tcb_rsp_pipe

`default_nettype wire

//--- logic/tcb_sub_ctl.sv
// subordinate handshake, ready generation, transfer detect, address decode
`timescale 1ns/1ps
`default_nettype none

module tcb_sub_ctl #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire logic              tcb,
  input  wire logic              rst_n,
  // manager request
  input  wire logic              vld,
  input  wire tcb_pkg::tcb_req_t req,
  // back-pressure level
  input  wire logic              stall,
  // handshake
  output logic                   rdy,
  output logic                   trn,
  // decode towards memory and response pipe
  output logic                   wr_en,
  output logic                   adr_ok,
  output tcb_pkg::tcb_widx_t     widx
);

  //////////////////////////////
  // reset release
  //////////////////////////////

  // set on the first edge with rst_n high
  logic rst_done;

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rst_done <= 1'b0;
    end else begin
      rst_done <= 1'b1;
    end
  end

  //////////////////////////////
  // handshake
  //////////////////////////////

  // ready only out of reset and not stalled
  // stall acts in the same cycle
  assign rdy = rst_done & ~stall;

  // transfer on vld and rdy both high
  assign trn = vld & rdy;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // drop the byte offset
  assign widx = req.adr[tcb_pkg::ABW-1:2];

  // compare at 32 bits, MEM_WORDS may equal 2**WIW
  assign adr_ok = (32'(widx) < MEM_WORDS);

  // out of range writes are dropped here
  assign wr_en = trn & req.wen & adr_ok;

endmodule : tcb_sub_ctl

`default_nettype wire

//--- sim/tcb_mem_checker.sv
// response checker with memory model, expected response queue and per-test results
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_checker #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire logic              tcb,
  input  wire logic              rst_n,
  // test id of the current stimulus line
  input  wire logic [7:0]        tid,
  // bus as seen on the DUT ports
  input  wire logic              vld,
  input  wire tcb_pkg::tcb_req_t req,
  input  wire logic              rdy,
  input  wire logic              rsp_vld,
  input  wire tcb_pkg::tcb_rsp_t rsp,
  // end of stimulus
  input  wire logic              fin,
  output int unsigned            pending,
  output int unsigned            tests_pass,
  output int unsigned            tests_fail,
  output int unsigned            chk_cnt,
  output int unsigned            err_cnt,
  output logic                   reported
);

  localparam int unsigned MIW = $clog2(MEM_WORDS);

  // expected response tagged with its test
  // chk low while the old word was never fully written
  typedef struct packed {
    logic [7:0]        tid;
    logic              chk;
    tcb_pkg::tcb_rsp_t rsp;
  } exp_t;

  //////////////////////////////
  // model state
  //////////////////////////////

  tcb_pkg::tcb_dat_t    model [0:MEM_WORDS-1];
  // words given defined content by full-word writes
  logic [MEM_WORDS-1:0] known;
  exp_t                 exp_q [$];

  // test whose responses are being compared
  logic [7:0]           cur_tid;
  int unsigned          cur_cnt;
  int unsigned          cur_err;

  // one result line for the finished test
  task automatic close_test();
    if (cur_cnt != 0 || cur_err != 0) begin
      if (cur_err == 0) begin
        tests_pass++;
        $display("test %0d passed, %0d responses", cur_tid, cur_cnt);
      end else begin
        tests_fail++;
        $display("test %0d failed, %0d of %0d responses wrong", cur_tid, cur_err, cur_cnt);
      end
    end
    cur_cnt = 0;
    cur_err = 0;
  endtask

  // pop the oldest expected response and compare
  task automatic take_response();
    exp_t e;
    if (exp_q.size() == 0) begin
      $display("response at %0d ns arrived with no transfer waiting for it", $time);
      err_cnt++;
      cur_err++;
    end else begin
      e = exp_q.pop_front();
      if (e.tid != cur_tid) begin
        close_test();
        cur_tid = e.tid;
      end
      cur_cnt++;
      chk_cnt++;
      if (rsp.err !== e.rsp.err || (e.chk && rsp.rdt !== e.rsp.rdt)) begin
        $display("[FAIL] %0d ns test %0d: got rdt %08h err %0b, expected rdt %08h err %0b",
                 $time, e.tid, rsp.rdt, rsp.err, e.rsp.rdt, e.rsp.err);
        err_cnt++;
        cur_err++;
      end
    end
  endtask

  // expected response from the old word then the write
  task automatic take_transfer();
    logic [MIW-1:0] mi;
    exp_t           e;
    // word select from the byte address
    mi    = req.adr[MIW+1:2];
    e.tid = tid;
    // the memory spans 4 * MEM_WORDS bytes
    if (32'(req.adr) < 4 * MEM_WORDS) begin
      e.chk     = known[mi];
      e.rsp.err = 1'b0;
      e.rsp.rdt = model[mi];
      if (req.wen) begin
        for (int unsigned b = 0; b < tcb_pkg::BEW; b++) begin
          if (req.ben[b]) begin
            model[mi][8*b +: 8] = req.wdt[8*b +: 8];
          end
        end
        if (&req.ben) begin
          known[mi] = 1'b1;
        end
      end
    end else begin
      // beyond the memory and no write at all
      e.chk     = 1'b1;
      e.rsp.err = 1'b1;
      e.rsp.rdt = '0;
    end
    exp_q.push_back(e);
  endtask

  //////////////////////////////
  // sampling
  //////////////////////////////

  // sampled on the falling edge where the bus is stable
  // responses first as they belong to older transfers
  always @(negedge tcb) begin
    if (!rst_n) begin
      exp_q.delete();
      known      = '0;
      cur_tid    = '0;
      cur_cnt    = 0;
      cur_err    = 0;
      tests_pass = 0;
      tests_fail = 0;
      chk_cnt    = 0;
      err_cnt    = 0;
      reported   = 1'b0;
    end else begin
      if (rsp_vld) begin
        take_response();
      end
      if (vld && rdy) begin
        take_transfer();
      end
      if (fin && !reported) begin
        close_test();
        if (exp_q.size() != 0) begin
          $display("%0d expected responses never arrived", exp_q.size());
          err_cnt += exp_q.size();
        end
        reported = 1'b1;
      end
    end
    pending = exp_q.size();
  end

endmodule : tcb_mem_checker

`default_nettype wire

//--- sim/tcb_mem_properties.sv
// bound assertions on ready during reset and under stall, and response strobe timing
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_properties #(
  parameter int unsigned DLY = 2
) (
  input wire logic tcb,
  input wire logic rst_n,
  input wire logic vld,
  input wire logic stall,
  input wire logic rdy,
  input wire logic rsp_vld
);

  // failures per assertion
  int unsigned fail_rst  = 0;
  int unsigned fail_stl  = 0;
  int unsigned fail_dly  = 0;
  int unsigned fail_orph = 0;
  int unsigned fail_cnt;

  assign fail_cnt = fail_rst + fail_stl + fail_dly + fail_orph;

  // rdy low in reset and on the first edge after it
  rdy_in_reset: assert property (@(posedge tcb) !rst_n |=> !rdy)
    else begin
      $error("rdy high during or right after reset");
      fail_rst++;
    end

  // past the first edge out of reset rdy is the inverse of stall
  rdy_tracks_stall: assert property (@(posedge tcb) disable iff (!rst_n)
    $past(rst_n) |-> (rdy == !stall))
    else begin
      $error("rdy does not follow stall out of reset");
      fail_stl++;
    end

  // strobe exactly DLY cycles after each transfer
  rsp_after_dly: assert property (@(posedge tcb) disable iff (!rst_n)
    (vld && rdy) |-> ##DLY rsp_vld)
    else begin
      $error("no response strobe DLY cycles after a transfer");
      fail_dly++;
    end

  // no strobe without a transfer DLY cycles back
  rsp_has_trn: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp_vld |-> $past(vld && rdy, DLY))
    else begin
      $error("response strobe without a matching transfer");
      fail_orph++;
    end

endmodule : tcb_mem_properties

bind tcb_mem_top tcb_mem_properties #(
  .DLY (DLY)
) tcb_mem_properties_i (
  .tcb     (tcb),
  .rst_n   (rst_n),
  .vld     (vld),
  .stall   (stall),
  .rdy     (rdy),
  .rsp_vld (rsp_vld)
);

`default_nettype wire

//--- sim/tcb_mem_stim.txt
// hex columns: test id, vld, wen, adr, ben, wdt, stall cycles
// stall keeps rdy low that many cycles first, on an idle line it is a level
// test id ff ends the stimulus
01 1 1 0000 f 00000000 0
01 1 1 0004 f 00000000 0
01 1 1 0008 f 00000000 0
01 1 1 000c f 00000000 0
01 1 1 0010 f 00000000 0
01 1 1 0014 f 00000000 0
01 1 1 0018 f 00000000 0
01 1 1 001c f 00000000 0
02 1 1 0008 f deadbeef 0
02 1 0 0008 f 00000000 0
02 1 1 000c f cafef00d 0
02 1 0 000c f 00000000 0
03 1 1 0010 1 000000aa 0
03 1 1 0010 4 00cc0000 0
03 1 0 0010 0 00000000 0
03 1 1 0014 c 55660000 1
03 1 0 0014 0 00000000 0
04 1 1 0008 f 11111111 0
04 1 1 0008 f 22222222 0
04 1 1 000c 2 0000ab00 0
04 1 0 0008 0 00000000 0
04 1 0 000c 0 00000000 0
05 1 1 0404 f ffffffff 0
05 1 0 0404 f 00000000 0
05 1 1 fffc f 12345678 0
05 1 0 0004 f 00000000 0
05 1 1 0400 f 87654321 0
05 1 0 0000 f 00000000 0
06 1 1 0018 f a5a5a5a5 0
06 1 1 001c f 5a5a5a5a 2
06 1 0 0018 f 00000000 0
06 0 0 0000 0 00000000 1
06 1 0 001c f 00000000 3
06 1 1 0018 3 0000ffff 0
06 1 0 0018 f 00000000 1
06 1 0 0800 f 00000000 0
ff 0 0 0000 0 00000000 0

//--- sim/tcb_mem_tb.sv
// testbench top, clock, reset, stimulus reader, request driver, timeout, summary
`timescale 1ns/1ps
`default_nettype none

module tcb_mem_tb;

  //////////////////////////////
  // settings
  //////////////////////////////

  localparam int unsigned DLY        = 2;
  localparam int unsigned MEM_WORDS  = 256;
  // hex columns per stimulus line
  localparam int unsigned COLS       = 7;
  localparam int unsigned STIM_LINES = 72;
  localparam int unsigned STIM_WORDS = 512;
  // test id of the closing line
  localparam logic [31:0] END_TID    = 32'hff;

  logic              tcb;
  logic              rst_n;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              stall;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_rsp_t rsp;

  // current test and end of stimulus, towards the checker
  logic [7:0]        tid;
  logic              fin;

  // results from the checker
  int unsigned       pending;
  int unsigned       tests_pass;
  int unsigned       tests_fail;
  int unsigned       chk_cnt;
  int unsigned       err_cnt;
  logic              reported;

  logic [31:0]       stim [0:STIM_WORDS-1];
  int unsigned       nlines;
  int unsigned       stall_sum;
  int unsigned       limit;
  int unsigned       cyc;
  int unsigned       drain;
  int unsigned       prop_fails;

  //////////////////////////////
  // DUT and checker
  //////////////////////////////

  tcb_mem_top #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) tcb_mem_top_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .stall   (stall),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  tcb_mem_checker #(
    .MEM_WORDS (MEM_WORDS)
  ) tcb_mem_checker_i (
    .tcb        (tcb),
    .rst_n      (rst_n),
    .tid        (tid),
    .vld        (vld),
    .req        (req),
    .rdy        (rdy),
    .rsp_vld    (rsp_vld),
    .rsp        (rsp),
    .fin        (fin),
    .pending    (pending),
    .tests_pass (tests_pass),
    .tests_fail (tests_fail),
    .chk_cnt    (chk_cnt),
    .err_cnt    (err_cnt),
    .reported   (reported)
  );

  // 4 ns period
  initial begin
    tcb = 1'b0;
    forever #2 tcb = ~tcb;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // read the file, count lines up to the closing id, sum the stall cycles
  task automatic load_stim();
    logic [8:0] base;
    $readmemh("sim/tcb_mem_stim.txt", stim);
    nlines    = 0;
    stall_sum = 0;
    base      = '0;
    while (nlines < STIM_LINES && stim[base] != END_TID) begin
      stall_sum += stim[base + 9'd6];
      nlines++;
      base = base + 9'(COLS);
    end
  endtask

  // one line, called 1 ns after a rising edge
  // a request is held until an edge with rdy high
  task automatic drive_line(input int unsigned n);
    logic [8:0]  base;
    int unsigned stall_left;
    logic        acc;
    base       = 9'(n * COLS);
    tid        = stim[base][7:0];
    vld        = stim[base + 9'd1][0];
    req.wen    = stim[base + 9'd2][0];
    req.adr    = stim[base + 9'd3][15:0];
    req.ben    = stim[base + 9'd4][3:0];
    req.wdt    = stim[base + 9'd5];
    stall_left = stim[base + 9'd6];
    stall      = (stall_left != 0);
    if (vld) begin
      acc = 1'b0;
      while (!acc) begin
        // rdy is stable in the low half
        @(negedge tcb);
        acc = rdy;
        @(posedge tcb);
        #1;
        if (stall_left != 0) begin
          stall_left--;
        end
        stall = (stall_left != 0);
      end
    end else begin
      // idle cycle, stall as a plain level
      @(posedge tcb);
      #1;
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    vld   = 1'b0;
    req   = '0;
    stall = 1'b0;
    tid   = '0;
    fin   = 1'b0;
    limit = 0;
    load_stim();
    limit = (nlines + stall_sum) * 4 + 50;
    // reset for 3 cycles
    repeat (3) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    for (int unsigned n = 0; n < nlines; n++) begin
      drive_line(n);
    end
    // quiet bus while the last responses drain
    vld   = 1'b0;
    stall = 1'b0;
    drain = 0;
    while (pending != 0 && drain < 2 * DLY + 4) begin
      @(posedge tcb);
      #1;
      drain++;
    end
    fin = 1'b1;
    while (!reported) begin
      @(posedge tcb);
    end
    prop_fails = tcb_mem_top_i.tcb_mem_properties_i.fail_cnt;
    $display("tests passed %0d, tests failed %0d, responses %0d, errors %0d, assertions %0d",
             tests_pass, tests_fail, chk_cnt, err_cnt, prop_fails);
    if (tests_fail == 0 && err_cnt == 0 && prop_fails == 0 && tests_pass != 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // cycle budget from the stimulus length
  initial begin
    cyc = 0;
    wait (limit != 0);
    while (cyc < limit) begin
      @(posedge tcb);
      cyc++;
    end
    $display("timeout after %0d cycles, the run did not complete", cyc);
    $display("Verification failed");
    $finish;
  end

endmodule : tcb_mem_tb

`default_nettype wire

//--- tcb_mem.f
logic/tcb_pkg.sv
logic/tcb_sub_ctl.sv
logic/tcb_mem_array.sv
logic/tcb_rsp_pipe.sv
logic/tcb_mem_top.sv
sim/tcb_mem_checker.sv
sim/tcb_mem_properties.sv
sim/tcb_mem_tb.sv
